//--- dac_half_select.sv
`timescale 1ns/1ps
`default_nettype none

`include "dac_params.svh"

// one half of the input bus: one-hot valid -> channel number + word
module dac_half_select
	import dac_pkg::*;
#(
	parameter int CHAN_BASE = 0                    // 0 for the lower half, 4 for the upper
) (
	input  wire  [`DAC_W_DATA*`DAC_N_CHAN/2-1:0] data_bus,  // four words, lowest channel in lsbs
	input  wire  [`DAC_N_CHAN/2-1:0]             valid,     // one-hot or zero
	output dac_instr_t                           instr,     // selected word with absolute channel
	output logic                                 hit        // any channel valid in this half
);

	localparam int W_SEL = $clog2(`DAC_N_CHAN/2);  // index width within a half

	logic [W_SEL-1:0] sel;                         // binary index from the one-hot valid
	logic             sel_err;                     // more than one valid bit set

	//////////////////////////////////////////////////////////////////////
	// one-hot decode
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		sel     = '0;
		sel_err = 1'b0;
		case (valid)
			4'b0000: sel = W_SEL'(0);              // idle, index is don't-care
			4'b0001: sel = W_SEL'(0);
			4'b0010: sel = W_SEL'(1);
			4'b0100: sel = W_SEL'(2);
			4'b1000: sel = W_SEL'(3);
			default: sel_err = 1'b1;               // preprocessor broke the half rule
		endcase
		// a multi-hot half would silently drop channels
		assert (!sel_err)
			else $error("dac_half_select base %0d: valid %b not one-hot", CHAN_BASE, valid);
	end

	//////////////////////////////////////////////////////////////////////
	// word select and channel offset
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		instr.data = data_bus[sel*`DAC_W_DATA +: `DAC_W_DATA];   // mux the chosen word
		instr.chan = dac_chan_t'(CHAN_BASE) + dac_chan_t'(sel);  // half base + local index
	end

	assign hit = |valid;                           // reduction or of this half

endmodule

`default_nettype wire

//--- dac_instr_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "dac_params.svh"

// first-word-fall-through queue of dac instructions
module dac_instr_fifo
	import dac_pkg::*;
(
	input  wire        clk_in,
	input  wire        rst,
	input  dac_instr_t din,                        // instruction to enqueue
	input  wire        wr_en,                      // enqueue strobe
	input  wire        rd_ack,                     // pop the head, only while valid
	output dac_instr_t dout,                       // current head
	output logic       valid                       // head holds a real entry
);

	localparam int W_PTR = $clog2(`DAC_FIFO_DEPTH);

	dac_instr_t       mem [`DAC_FIFO_DEPTH];       // circular storage
	logic [W_PTR-1:0] wr_ptr;                      // next slot to write
	logic [W_PTR-1:0] rd_ptr;                      // slot shown on dout
	logic [W_PTR:0]   count;                       // entries held, one extra bit for full
	logic             full;
	logic             do_wr;
	logic             do_rd;

	assign full  = (count == (W_PTR+1)'(`DAC_FIFO_DEPTH));
	assign do_wr = wr_en && !full;                 // overflow is dropped, assertion below
	assign do_rd = rd_ack && valid;

	//////////////////////////////////////////////////////////////////////
	// storage
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (do_wr)
			mem[wr_ptr] <= din;
	end

	//////////////////////////////////////////////////////////////////////
	// pointers and count
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;           // wraps at the power-of-two depth
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;           // next entry falls through a cycle later
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;           // both or neither
			endcase
		end
	end

	// count is registered, so valid rises one cycle after the first write
	assign valid = (count != '0);
	assign dout  = mem[rd_ptr];                    // head always on the output

	//////////////////////////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////////////////////////

	// the input side has no back-pressure, so depth must cover the burst
	a_no_overflow: assert property (@(posedge clk_in) disable iff (rst) !(wr_en && full))
		else $error("dac_instr_fifo: write while full, instruction lost");

	// reader may only acknowledge a head that is there
	a_no_underflow: assert property (@(posedge clk_in) disable iff (rst) !(rd_ack && !valid))
		else $error("dac_instr_fifo: rd_ack while empty");

endmodule

`default_nettype wire

//--- dac_instr_merge.sv
`timescale 1ns/1ps
`default_nettype none

`include "dac_params.svh"

// serialize the two half instructions into one queue, lower half first
module dac_instr_merge
	import dac_pkg::*;
(
	input  wire        clk_in,
	input  wire        rst,
	input  dac_instr_t lower_instr,                // from the channel 0..3 selector
	input  wire        lower_hit,
	input  dac_instr_t upper_instr,                // from the channel 4..7 selector
	input  wire        upper_hit,
	input  wire        rd_ack,                     // pop strobe from the writer
	output dac_instr_t head,                       // queue head for the writer
	output logic       head_valid
);

	dac_instr_t upper_instr_q;                     // upper instruction held one cycle
	logic       upper_hit_q;
	dac_instr_t fifo_din;
	logic       fifo_wr;

	//////////////////////////////////////////////////////////////////////
	// upper half delay
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (rst)
			upper_hit_q <= 1'b0;
		else
			upper_hit_q <= upper_hit;
	end

	always_ff @(posedge clk_in) begin
		upper_instr_q <= upper_instr;              // only looked at when upper_hit_q is set
	end

	// lower goes in on arrival, delayed upper takes the next slot
	assign fifo_din = lower_hit ? lower_instr : upper_instr_q;
	assign fifo_wr  = lower_hit | upper_hit_q;

	//////////////////////////////////////////////////////////////////////
	// queue
	//////////////////////////////////////////////////////////////////////

	dac_instr_fifo instr_fifo (
		.clk_in (clk_in),
		.rst    (rst),
		.din    (fifo_din),
		.wr_en  (fifo_wr),
		.rd_ack (rd_ack),
		.dout   (head),
		.valid  (head_valid)
	);

	// input events must be two cycles apart or a delayed upper gets overwritten
	a_pacing: assert property (@(posedge clk_in) disable iff (rst) !(lower_hit && upper_hit_q))
		else $error("dac_instr_merge: valid events closer than two cycles");

endmodule

`default_nettype wire

//--- dac_params.svh
`ifndef DAC_PARAMS_SVH
`define DAC_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// dac write path constants
//////////////////////////////////////////////////////////////////////

`define DAC_W_DATA      16      // bits per dac data word
`define DAC_W_CHS       3       // bits per channel number
`define DAC_N_CHAN      8       // channels from the preprocessor, two halves of four

// one instruction is channel then data
`define DAC_W_INSTR     (`DAC_W_CHS + `DAC_W_DATA)

`define DAC_FIFO_DEPTH  16      // queue entries, power of two
`define DAC_SCLK_DIV    2       // clk_in cycles per sclk half period

`endif

//--- dac_pkg.sv
`default_nettype none

`include "dac_params.svh"

package dac_pkg;

	//////////////////////////////////////////////////////////////////////
	// payload types
	//////////////////////////////////////////////////////////////////////

	typedef logic [`DAC_W_DATA-1:0] dac_data_t;    // one dac sample word
	typedef logic [`DAC_W_CHS-1:0]  dac_chan_t;    // dac channel 0..7

	// write instruction, stored in the queue and sent as one frame
	// chan lands in the msbs so it goes out first
	typedef struct packed {
		dac_chan_t chan;                           // target channel
		dac_data_t data;                           // sample word
	} dac_instr_t;

	//////////////////////////////////////////////////////////////////////
	// serial writer states
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		spi_idle  = 2'd0,                          // waiting for a queued instruction
		spi_load  = 2'd1,                          // pop head into the shift register
		spi_shift = 2'd2,                          // frame on the wire, sync low
		spi_gap   = 2'd3                           // sync high between frames
	} spi_state_t;

endpackage

`default_nettype wire

//--- dac_spi_writer.sv
`timescale 1ns/1ps
`default_nettype none

`include "dac_params.svh"

// pops queued instructions and shifts each out as one dac frame
module dac_spi_writer
	import dac_pkg::*;
(
	input  wire        clk_in,
	input  wire        rst,
	input  dac_instr_t head,                       // fifo head, valid with head_valid
	input  wire        head_valid,
	output logic       rd_ack,                     // one-cycle pop pulse
	output logic       dac_sclk,                   // idles low
	output logic       dac_sync_n,                 // low for the whole frame
	output logic       dac_sdin                    // msb first, changes on sclk fall
);

	localparam int W_BIT     = $clog2(`DAC_W_INSTR);
	localparam int GAP_CYC   = 2;                  // sync high time between frames
	localparam int W_CYC     = $clog2(`DAC_SCLK_DIV + GAP_CYC);
	localparam int FRAME_CYC = `DAC_W_INSTR * 2 * `DAC_SCLK_DIV;

	spi_state_t              state;
	logic [`DAC_W_INSTR-1:0] shreg;                // frame being sent, msb on the pin
	logic [W_BIT-1:0]        bit_cnt;              // bits already clocked out
	logic [W_CYC-1:0]        cyc_cnt;              // sclk half period, reused for the gap

	assign dac_sdin = shreg[`DAC_W_INSTR-1];

	//////////////////////////////////////////////////////////////////////
	// frame FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (rst) begin
			state      <= spi_idle;
			rd_ack     <= 1'b0;
			dac_sclk   <= 1'b0;
			dac_sync_n <= 1'b1;
			shreg      <= '0;
			bit_cnt    <= '0;
			cyc_cnt    <= '0;
		end else begin
			rd_ack <= 1'b0;                        // pulse, one cycle at most
			case (state)
				spi_idle: begin
					if (head_valid) begin
						rd_ack <= 1'b1;            // high during load, head still valid then
						state  <= spi_load;
					end
				end
				spi_load: begin
					shreg      <= head;            // capture before the pop takes effect
					dac_sync_n <= 1'b0;            // frame starts next cycle
					bit_cnt    <= '0;
					cyc_cnt    <= '0;
					state      <= spi_shift;
				end
				spi_shift: begin
					if (cyc_cnt == W_CYC'(`DAC_SCLK_DIV - 1)) begin
						cyc_cnt  <= '0;
						dac_sclk <= ~dac_sclk;
						if (dac_sclk) begin        // falling edge, move to next bit
							if (bit_cnt == W_BIT'(`DAC_W_INSTR - 1)) begin
								dac_sync_n <= 1'b1;    // last bit sampled, close frame
								state      <= spi_gap;
							end else begin
								bit_cnt <= bit_cnt + 1'b1;
								shreg   <= {shreg[`DAC_W_INSTR-2:0], 1'b0};
							end
						end
					end else begin
						cyc_cnt <= cyc_cnt + 1'b1;
					end
				end
				spi_gap: begin
					if (cyc_cnt == W_CYC'(GAP_CYC - 1)) begin
						cyc_cnt <= '0;
						state   <= spi_idle;
					end else begin
						cyc_cnt <= cyc_cnt + 1'b1;
					end
				end
				default: state <= spi_idle;
			endcase
		end
	end

	// sync must come back up exactly one frame length after it falls
	a_frame_len: assert property (@(posedge clk_in) disable iff (rst)
		$fell(dac_sync_n) |-> ##FRAME_CYC $rose(dac_sync_n))
		else $error("dac_spi_writer: frame length is not %0d cycles", FRAME_CYC);

endmodule

`default_nettype wire

//--- dac_write_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "dac_params.svh"

// dac write path: two half selectors -> merge queue -> serial writer
module dac_write_top
	import dac_pkg::*;
(
	input  wire                                clk_in,
	input  wire                                rst,
	input  wire [`DAC_W_DATA*`DAC_N_CHAN-1:0]  data_bus,     // channel 0 in the lsbs
	input  wire [`DAC_N_CHAN-1:0]              data_valid,   // each half one-hot or zero
	output logic                               dac_sclk,
	output logic                               dac_sync_n,
	output logic                               dac_sdin
);

	dac_instr_t lower_instr;                       // channels 0..3
	logic       lower_hit;
	dac_instr_t upper_instr;                       // channels 4..7
	logic       upper_hit;
	dac_instr_t head;                              // queue head to the writer
	logic       head_valid;
	logic       rd_ack;

	//////////////////////////////////////////////////////////////////////
	// half selectors
	//////////////////////////////////////////////////////////////////////

	dac_half_select #(.CHAN_BASE(0)) lower_select (
		.data_bus (data_bus[`DAC_W_DATA*`DAC_N_CHAN/2-1:0]),
		.valid    (data_valid[`DAC_N_CHAN/2-1:0]),
		.instr    (lower_instr),
		.hit      (lower_hit)
	);

	dac_half_select #(.CHAN_BASE(`DAC_N_CHAN/2)) upper_select (
		.data_bus (data_bus[`DAC_W_DATA*`DAC_N_CHAN-1:`DAC_W_DATA*`DAC_N_CHAN/2]),
		.valid    (data_valid[`DAC_N_CHAN-1:`DAC_N_CHAN/2]),
		.instr    (upper_instr),
		.hit      (upper_hit)
	);

	//////////////////////////////////////////////////////////////////////
	// queue and writer
	//////////////////////////////////////////////////////////////////////

	dac_instr_merge dac_instr_merge_inst (
		.clk_in      (clk_in),
		.rst         (rst),
		.lower_instr (lower_instr),
		.lower_hit   (lower_hit),
		.upper_instr (upper_instr),
		.upper_hit   (upper_hit),
		.rd_ack      (rd_ack),
		.head        (head),
		.head_valid  (head_valid)
	);

	dac_spi_writer dac_spi_writer_inst (
		.clk_in     (clk_in),
		.rst        (rst),
		.head       (head),
		.head_valid (head_valid),
		.rd_ack     (rd_ack),
		.dac_sclk   (dac_sclk),
		.dac_sync_n (dac_sync_n),
		.dac_sdin   (dac_sdin)
	);

endmodule

`default_nettype wire

//--- files.f
+incdir+.
dac_pkg.sv
dac_half_select.sv
dac_instr_fifo.sv
dac_instr_merge.sv
dac_spi_writer.sv
dac_write_top.sv
tb_dac_write.sv

//--- run_sim.sh
#!/bin/sh
# build the dac write testbench with verilator, run it, and judge the log
rm -f sim.log
verilator --binary --assert -Wno-fatal --top-module tb_dac_write -f files.f \
	-o tb_dac_write_sim \
	&& ./obj_dir/tb_dac_write_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Result: PASSED" sim.log && echo "simulation passed" && exit 0 \
	|| echo "simulation failed" && exit 1

//--- tb_dac_write.sv
`timescale 1ns/1ps
`default_nettype none

`include "dac_params.svh"

module tb_dac_write
	import dac_pkg::*;
();

	localparam int HALF      = `DAC_N_CHAN / 2;
	localparam int W_BUS     = `DAC_W_DATA * `DAC_N_CHAN;
	localparam int FRAME_BIT = `DAC_W_CHS + `DAC_W_DATA;        // channel bits then data bits
	localparam int FRAME_CYC = FRAME_BIT * 2 * `DAC_SCLK_DIV;   // clk_in cycles with sync low

	logic                   clk_in;
	logic                   rst;
	logic [W_BUS-1:0]       data_bus;
	logic [`DAC_N_CHAN-1:0] data_valid;
	logic                   dac_sclk;
	logic                   dac_sync_n;
	logic                   dac_sdin;

	dac_instr_t             exp_q[$];         // instructions in the order frames must leave
	integer                 seed;
	string                  test_name;
	int                     err_cnt;
	int                     test_err0;        // err_cnt when the current test began
	int                     frames0;          // frames_seen when the current test began
	int                     pass_cnt;
	int                     fail_cnt;
	logic                   quiet;            // input idle window, lines must stay parked
	spi_state_t             wr_state;

	// frame capture
	logic                   sclk_d;
	logic                   sync_d;
	logic [FRAME_BIT-1:0]   cap_sr;
	int                     cap_bits;
	int                     low_cnt;          // edges that saw sync low
	logic                   frame_done;       // one-cycle pulse after a frame closes
	dac_instr_t             frame_got;
	dac_instr_t             frame_exp;
	logic                   frame_owed;       // queue held an entry for this frame
	int                     frame_bits;
	int                     frame_len;
	int                     frames_seen;

	dac_write_top dac_write_top_inst (
		.clk_in     (clk_in),
		.rst        (rst),
		.data_bus   (data_bus),
		.data_valid (data_valid),
		.dac_sclk   (dac_sclk),
		.dac_sync_n (dac_sync_n),
		.dac_sdin   (dac_sdin)
	);

	assign wr_state = dac_write_top_inst.dac_spi_writer_inst.state;  // for timeout messages

	initial clk_in = 1'b0;
	always #4 clk_in = ~clk_in;                   // 8 ns period

	//////////////////////////////////////////////////////////////////////
	// frame capture, all on clk_in with pre-edge values
	//////////////////////////////////////////////////////////////////////

	always @(posedge clk_in) begin
		if (rst) begin
			sclk_d      <= 1'b0;
			sync_d      <= 1'b1;
			cap_sr      <= '0;
			cap_bits    <= 0;
			low_cnt     <= 0;
			frame_done  <= 1'b0;
			frames_seen <= 0;
		end else begin
			sclk_d     <= dac_sclk;
			sync_d     <= dac_sync_n;
			frame_done <= 1'b0;
			if (sync_d && !dac_sync_n) begin      // sync fell at the last edge
				cap_sr   <= '0;
				cap_bits <= 0;
				low_cnt  <= 1;
			end else if (!dac_sync_n) begin
				low_cnt <= low_cnt + 1;
				if (dac_sclk && !sclk_d) begin    // sclk rose, sdin has been stable since the fall
					cap_sr   <= {cap_sr[FRAME_BIT-2:0], dac_sdin};
					cap_bits <= cap_bits + 1;
				end
			end
			if (!sync_d && dac_sync_n) begin      // frame closed
				frame_done  <= 1'b1;
				frame_got   <= cap_sr;
				frame_bits  <= cap_bits;
				frame_len   <= low_cnt;
				frame_owed  <= (exp_q.size() != 0);
				frame_exp   <= (exp_q.size() != 0) ? exp_q[0] : '0;
				frames_seen <= frames_seen + 1;
				if (exp_q.size() != 0)
					exp_q.pop_front();
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////////////////////////

	a_frame_owed: assert property (@(posedge clk_in) disable iff (rst) frame_done |-> frame_owed)
		else begin
			$display("%s: a frame came out with no instruction queued for it", test_name);
			err_cnt++;
		end

	a_frame_data: assert property (@(posedge clk_in) disable iff (rst)
		frame_done && frame_owed |-> frame_got == frame_exp)
		else begin
			$display("Mismatch %s frame chan/data: expected %h actual %h",
				test_name, frame_exp, frame_got);
			err_cnt++;
		end

	a_frame_bits: assert property (@(posedge clk_in) disable iff (rst)
		frame_done |-> frame_bits == FRAME_BIT)
		else begin
			$display("Mismatch %s sclk rises per frame: expected %0d actual %0d",
				test_name, FRAME_BIT, frame_bits);
			err_cnt++;
		end

	// sync low window must match 19 bits of 2*DIV cycles each
	a_frame_len: assert property (@(posedge clk_in) disable iff (rst)
		frame_done |-> frame_len == FRAME_CYC)
		else begin
			$display("Mismatch %s sync low cycles: expected %0d actual %0d",
				test_name, FRAME_CYC, frame_len);
			err_cnt++;
		end

	a_sclk_parked: assert property (@(posedge clk_in) disable iff (rst) dac_sync_n |-> !dac_sclk)
		else begin
			$display("%s: dac_sclk high while no frame is open", test_name);
			err_cnt++;
		end

	a_quiet: assert property (@(posedge clk_in) disable iff (rst) quiet |-> dac_sync_n)
		else begin
			$display("%s: a frame started while the input was idle", test_name);
			err_cnt++;
		end

	//////////////////////////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////////////////////////

	function automatic int onehot_index(input logic [HALF-1:0] oh);
		int i;
		onehot_index = 0;
		for (i = 0; i < HALF; i++)
			if (oh[i])
				onehot_index = i;
	endfunction

	// expected order: lower half entry, then upper half entry
	task automatic push_expected(input logic [`DAC_N_CHAN-1:0] v, input logic [W_BUS-1:0] bus);
		dac_instr_t e;
		int         idx;
		if (v[HALF-1:0] != '0) begin
			idx    = onehot_index(v[HALF-1:0]);
			e.chan = dac_chan_t'(idx);
			e.data = bus[idx*`DAC_W_DATA +: `DAC_W_DATA];
			exp_q.push_back(e);
		end
		if (v[`DAC_N_CHAN-1:HALF] != '0) begin
			idx    = HALF + onehot_index(v[`DAC_N_CHAN-1:HALF]);  // upper half base
			e.chan = dac_chan_t'(idx);
			e.data = bus[idx*`DAC_W_DATA +: `DAC_W_DATA];
			exp_q.push_back(e);
		end
	endtask

	task automatic random_bus(output logic [W_BUS-1:0] bus);
		int i;
		for (i = 0; i < `DAC_N_CHAN; i++)
			bus[i*`DAC_W_DATA +: `DAC_W_DATA] = dac_data_t'($random(seed));
	endtask

	// one valid cycle then one idle cycle keeps events two cycles apart
	task automatic send_event(input logic [`DAC_N_CHAN-1:0] v, input logic [W_BUS-1:0] bus);
		@(posedge clk_in);
		#1;
		data_bus   = bus;
		data_valid = v;
		push_expected(v, bus);
		@(posedge clk_in);
		#1;
		data_valid = '0;
	endtask

	task automatic send_random(input logic [`DAC_N_CHAN-1:0] v);
		logic [W_BUS-1:0] bus;
		random_bus(bus);
		send_event(v, bus);
	endtask

	task automatic wait_drained(input int limit);
		int n;
		n = 0;
		while ((exp_q.size() != 0 || !dac_sync_n || frame_done) && n < limit) begin
			@(posedge clk_in);
			#1;
			n++;
		end
		if (exp_q.size() != 0 || !dac_sync_n || frame_done) begin
			$display("%s: timed out after %0d cycles waiting for frames, %0d still queued, writer %s",
				test_name, limit, exp_q.size(), wr_state.name());
			err_cnt++;
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_err0 = err_cnt;
		frames0   = frames_seen;
	endtask

	task automatic finish_test(input int want_frames);
		assert (frames_seen - frames0 == want_frames)
			else begin
				$display("Mismatch %s frame count: expected %0d actual %0d",
					test_name, want_frames, frames_seen - frames0);
				err_cnt++;
			end
		if (err_cnt == test_err0) begin
			pass_cnt++;
			$display("test %s: ok", test_name);
		end else begin
			fail_cnt++;
			$display("test %s: %0d errors", test_name, err_cnt - test_err0);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////////////////////////

	initial begin
		logic [`DAC_N_CHAN-1:0] v;
		int                     i;
		seed       = 32'hc07c0191;
		err_cnt    = 0;
		pass_cnt   = 0;
		fail_cnt   = 0;
		test_name  = "reset";
		quiet      = 1'b0;
		rst        = 1'b1;
		data_bus   = '0;
		data_valid = '0;
		repeat (5) @(posedge clk_in);
		#1;
		rst = 1'b0;

		start_test("reset_idle");                 // lines parked, nothing sent
		quiet = 1'b1;
		for (i = 0; i < 40; i++)
			@(posedge clk_in);
		#1;
		quiet = 1'b0;
		finish_test(0);

		start_test("lower_single");
		send_random(8'b0000_0100);                // channel 2
		wait_drained(200);
		finish_test(1);

		start_test("upper_single");
		send_random(8'b0010_0000);                // channel 5
		wait_drained(200);
		finish_test(1);

		start_test("pair_order");
		send_random(8'b1000_0001);                // channel 0 then 7
		wait_drained(300);
		finish_test(2);

		start_test("random_burst");               // 14 entries pile up behind the writer
		for (i = 0; i < 7; i++) begin
			v = '0;
			v[$unsigned($random(seed)) % HALF]        = 1'b1;
			v[HALF + $unsigned($random(seed)) % HALF] = 1'b1;
			send_random(v);
		end
		wait_drained(2000);
		finish_test(14);

		start_test("frame_timing");               // channels 3 and 4, length checked per frame
		send_random(8'b0001_1000);
		wait_drained(300);
		finish_test(2);

		$display("tests %0d, ok %0d, failing %0d, errors %0d",
			pass_cnt + fail_cnt, pass_cnt, fail_cnt, err_cnt);
		if (err_cnt == 0 && fail_cnt == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire
